/* Makefile */
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= controlUnit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* controlUnit.f */
+incdir+hw
hw/controlUnitPkg.sv
hw/opcodeDecoder.sv
hw/instrSequencer.sv
hw/controlUnit.sv
dv/controlUnitChecker.sv
dv/controlUnitTb.sv

/* dv/controlUnitChecker.sv */
`include "controlUnit_defines.svh"

module controlUnitChecker import controlUnitPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic                checkEn, // a table row is applied in this cycle
    input  ctrlWordT            ctrl,
    input  logic [`ALUOP_W-1:0] aluOp,
    input  logic                shift,
    input  stackOpT             stackOp,
    input  logic                isPush,
    input  logic                isIn,
    input  phaseT               callPhase,
    input  phaseT               retPhase,
    input  phaseT               intPhase,
    input  ctrlWordT            expCtrl,
    input  logic [`ALUOP_W-1:0] expAluOp,
    input  logic                expShift,
    input  stackOpT             expStackOp,
    input  logic                expIsPush,
    input  logic                expIsIn,
    input  phaseT               expCallPhase,
    input  phaseT               expRetPhase,
    input  phaseT               expIntPhase,
    output int                  mismatchCnt,
    output int                  otherCnt,
    output int                  checkedRows // also the index of the row under check
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_TIMEOUT = 50; // cycles to wait for arstN to rise

    task automatic compareField(input string name, input logic [7:0] got,
                                input logic [7:0] want);
        if (got !== want) begin
            $display("mismatch %s got 0x%02h expected 0x%02h in row %0d",
                     name, got, want, checkedRows);
            mismatchCnt++;
        end
    endtask

    initial begin : watch
        int waited;
        mismatchCnt = 0;
        otherCnt    = 0;
        checkedRows = 0;
        waited      = 0;
        while (arstN !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (arstN !== 1'b1) begin
            $display("timeout: the reset was never released");
            otherCnt++;
        end else begin
            // the combinational outputs have settled well before 30 ns
            forever begin
                #30;
                if (checkEn) begin
                    compareField("ctrl", 8'(ctrl), 8'(expCtrl));
                    compareField("aluOp", 8'(aluOp), 8'(expAluOp));
                    compareField("shift", 8'(shift), 8'(expShift));
                    compareField("stackOp", 8'(stackOp), 8'(expStackOp));
                    compareField("isPush", 8'(isPush), 8'(expIsPush));
                    compareField("isIn", 8'(isIn), 8'(expIsIn));
                    compareField("callPhase", 8'(callPhase), 8'(expCallPhase));
                    compareField("retPhase", 8'(retPhase), 8'(expRetPhase));
                    compareField("intPhase", 8'(intPhase), 8'(expIntPhase));
                    checkedRows++;
                end
                @(posedge clk);
            end
        end
    end

endmodule

/* dv/controlUnitTb.sv */
`include "controlUnit_defines.svh"

module controlUnitTb import controlUnitPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS     = 64;
    localparam int DONE_TIMEOUT = 20; // cycles for the checker to finish the last row

    // one clock cycle of stimulus together with the outputs it must produce
    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [1:0]           stim; // {bubble, interrupt}
        logic [6:0]           ctrl; // {ir, iw, mr, mw, mtr, rw, branch}
        logic [`ALUOP_W-1:0]  aluOp;
        stackOpT              stackOp;
        logic [2:0]           flags; // {shift, isPush, isIn}
        logic [5:0]           phases; // {callPhase, retPhase, intPhase}
    } rowT;

    logic                 clk;
    logic                 arstN;
    logic [`OPCODE_W-1:0] opcode;
    logic                 bubble;
    logic                 interrupt;
    ctrlWordT             ctrl;
    logic [`ALUOP_W-1:0]  aluOp;
    logic                 shift;
    stackOpT              stackOp;
    logic                 isPush;
    logic                 isIn;
    phaseT                callPhase;
    phaseT                retPhase;
    phaseT                intPhase;
    logic                 checkEn;
    ctrlWordT             expCtrl;
    logic [`ALUOP_W-1:0]  expAluOp;
    logic                 expShift;
    stackOpT              expStackOp;
    logic                 expIsPush;
    logic                 expIsIn;
    phaseT                expCallPhase;
    phaseT                expRetPhase;
    phaseT                expIntPhase;
    int                   mismatchCnt;
    int                   otherCnt;
    int                   checkedRows;
    logic                 timedOut;
    rowT                  stimTable [MAX_ROWS];
    int                   rowCount;

    controlUnit UUT (.*);

    controlUnitChecker controlUnitChecker (.*);

    initial begin : clockGen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic addRow(input logic [`OPCODE_W-1:0] op, input logic [1:0] stim,
                          input logic [6:0] ctrlBits, input logic [`ALUOP_W-1:0] alu,
                          input stackOpT stack, input logic [2:0] flags,
                          input logic [5:0] phases);
        stimTable[rowCount] = {op, stim, ctrlBits, alu, stack, flags, phases};
        rowCount++;
    endtask

    // drives the DUT inputs and hands the expected outputs to the checker
    task automatic applyRow(input rowT row);
        opcode       = row.opcode;
        bubble       = row.stim[1];
        interrupt    = row.stim[0];
        expCtrl      = ctrlWordT'(row.ctrl);
        expAluOp     = row.aluOp;
        expStackOp   = row.stackOp;
        {expShift, expIsPush, expIsIn} = row.flags;
        expCallPhase = phaseT'(row.phases[5:4]);
        expRetPhase  = phaseT'(row.phases[3:2]);
        expIntPhase  = phaseT'(row.phases[1:0]);
        checkEn      = 1'b1;
    endtask

    // phase pairs read 11 for the first half and 01 for the second
    task automatic fillTable();
        rowCount = 0;
        addRow(`OP_NOP,  2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_NOT,  2'b00, 7'b0000010, `ALU_NOT,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_INC,  2'b00, 7'b0000010, `ALU_INC,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_DEC,  2'b00, 7'b0000010, `ALU_DEC,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_MOV,  2'b00, 7'b0000010, `ALU_MOV,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_ADD,  2'b00, 7'b0000010, `ALU_ADD,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_SUB,  2'b00, 7'b0000010, `ALU_SUB,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_AND,  2'b00, 7'b0000010, `ALU_AND,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_OR,   2'b00, 7'b0000010, `ALU_OR,   STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_SHL,  2'b00, 7'b0000010, `ALU_SHL,  STACK_NONE, 3'b100, 6'b00_00_00);
        addRow(`OP_SHR,  2'b00, 7'b0000010, `ALU_SHR,  STACK_NONE, 3'b100, 6'b00_00_00);
        addRow(`OP_PUSH, 2'b00, 7'b0001000, `ALU_MOV,  STACK_PUSH, 3'b010, 6'b00_00_00);
        addRow(`OP_POP,  2'b00, 7'b0010110, `ALU_MOV,  STACK_POP,  3'b000, 6'b00_00_00);
        addRow(`OP_LDD,  2'b00, 7'b0010110, `ALU_LDD,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_STD,  2'b00, 7'b0001000, `ALU_STD,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_JZ,   2'b00, 7'b0000000, `ALU_JZ,   STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_JN,   2'b00, 7'b0000000, `ALU_JN,   STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_JC,   2'b00, 7'b0000000, `ALU_JC,   STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_JMP,  2'b00, 7'b0000000, `ALU_JMP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_OUT,  2'b00, 7'b0100000, `ALU_MOV,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_IN,   2'b00, 7'b1000010, `ALU_MOV,  STACK_NONE, 3'b001, 6'b00_00_00);
        addRow(`OP_SETC, 2'b00, 7'b0000000, `ALU_SETC, STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_CLRC, 2'b00, 7'b0000000, `ALU_CLRC, STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(5'd30,    2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        // LDM is a bubble and then writes its immediate no matter what sits in decode
        addRow(`OP_LDM,  2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_ADD,  2'b00, 7'b0000010, `ALU_MOV,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_CALL, 2'b00, 7'b0001000, `ALU_STD,  STACK_PUSH, 3'b000, 6'b11_00_00);
        addRow(`OP_NOP,  2'b00, 7'b0001000, `ALU_NOP,  STACK_PUSH, 3'b000, 6'b01_00_00);
        // RET and RTI are followed by two flushed slots
        addRow(`OP_RET,  2'b00, 7'b0010000, `ALU_MOV,  STACK_POP,  3'b000, 6'b00_11_00);
        addRow(`OP_ADD,  2'b00, 7'b0010000, `ALU_MOV,  STACK_POP,  3'b000, 6'b00_01_00);
        addRow(`OP_ADD,  2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_PUSH, 2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_RTI,  2'b00, 7'b0010000, `ALU_RTI,  STACK_POP,  3'b000, 6'b00_11_00);
        addRow(`OP_INC,  2'b00, 7'b0010000, `ALU_MOV,  STACK_POP,  3'b000, 6'b00_01_00);
        addRow(`OP_INC,  2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_INC,  2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_INC,  2'b00, 7'b0000010, `ALU_INC,  STACK_NONE, 3'b000, 6'b00_00_00);
        // a stall held across the CALL delays its second push until the bubble drops
        addRow(`OP_CALL, 2'b00, 7'b0001000, `ALU_STD,  STACK_PUSH, 3'b000, 6'b11_00_00);
        addRow(`OP_CALL, 2'b10, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_ADD,  2'b10, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_NOP,  2'b00, 7'b0001000, `ALU_NOP,  STACK_PUSH, 3'b000, 6'b01_00_00);
        // interrupt while idle and then one that lands on the LDM immediate slot
        addRow(`OP_NOP,  2'b01, 7'b0001000, `ALU_NOP,  STACK_PUSH, 3'b000, 6'b00_00_11);
        addRow(`OP_ADD,  2'b00, 7'b0001000, `ALU_NOP,  STACK_PUSH, 3'b000, 6'b00_00_01);
        addRow(`OP_LDM,  2'b00, 7'b0000000, `ALU_NOP,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_ADD,  2'b01, 7'b0000010, `ALU_MOV,  STACK_NONE, 3'b000, 6'b00_00_00);
        addRow(`OP_ADD,  2'b00, 7'b0001000, `ALU_NOP,  STACK_PUSH, 3'b000, 6'b00_00_11);
        addRow(`OP_ADD,  2'b00, 7'b0001000, `ALU_NOP,  STACK_PUSH, 3'b000, 6'b00_00_01);
        addRow(`OP_ADD,  2'b00, 7'b0000010, `ALU_ADD,  STACK_NONE, 3'b000, 6'b00_00_00);
    endtask

    initial begin : stimulus
        int waited;
        arstN    = 1'b0;
        timedOut = 1'b0;
        applyRow('0); // inputs start as a NOP with nothing to check
        checkEn  = 1'b0;
        fillTable();
        repeat (3) @(posedge clk);
        #5 arstN = 1'b1;
        for (int i = 0; i < rowCount; i++) begin
            @(posedge clk);
            #5;
            applyRow(stimTable[i]);
        end
        waited = 0;
        while (checkedRows < rowCount && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        checkEn = 1'b0; // keeps the checker off the stale last row
        if (checkedRows < rowCount) begin
            $display("timeout: the checker finished only %0d of %0d rows", checkedRows, rowCount);
            timedOut = 1'b1;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatchCnt,
                 otherCnt + (timedOut ? 1 : 0));
        if (mismatchCnt == 0 && otherCnt == 0 && !timedOut) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hw/controlUnit.sv */
`include "controlUnit_defines.svh"

module controlUnit import controlUnitPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [`OPCODE_W-1:0] opcode, // instruction in the decode stage
    input  logic                 bubble,
    input  logic                 interrupt,
    output ctrlWordT             ctrl,
    output logic [`ALUOP_W-1:0]  aluOp,
    output logic                 shift,
    output stackOpT              stackOp,
    output logic                 isPush,
    output logic                 isIn,
    output phaseT                callPhase,
    output phaseT                retPhase,
    output phaseT                intPhase
);

    // first-cycle fields straight from the decode table
    ctrlWordT            decCtrl;
    logic [`ALUOP_W-1:0] decAluOp;
    logic                decShift;
    stackOpT             decStackOp;
    logic                decIsPush;
    logic                decIsIn;
    phaseT               decCallPhase;
    phaseT               decRetPhase;
    seqStartT            seqStart; // multi-cycle instruction begins

    opcodeDecoder decoder (
        .opcode    (opcode),
        .ctrl      (decCtrl),
        .aluOp     (decAluOp),
        .shift     (decShift),
        .stackOp   (decStackOp),
        .isPush    (decIsPush),
        .isIn      (decIsIn),
        .callPhase (decCallPhase),
        .retPhase  (decRetPhase),
        .seqStart  (seqStart)
    );

    // the sequencer owns every output and overrides decode when it must
    instrSequencer sequencer (
        .clk          (clk),
        .arstN        (arstN),
        .bubble       (bubble),
        .interrupt    (interrupt),
        .decCtrl      (decCtrl),
        .decAluOp     (decAluOp),
        .decShift     (decShift),
        .decStackOp   (decStackOp),
        .decIsPush    (decIsPush),
        .decIsIn      (decIsIn),
        .decCallPhase (decCallPhase),
        .decRetPhase  (decRetPhase),
        .seqStart     (seqStart),
        .ctrl         (ctrl),
        .aluOp        (aluOp),
        .shift        (shift),
        .stackOp      (stackOp),
        .isPush       (isPush),
        .isIn         (isIn),
        .callPhase    (callPhase),
        .retPhase     (retPhase),
        .intPhase     (intPhase)
    );

endmodule

/* hw/controlUnitPkg.sv */
package controlUnitPkg;

    // one bit per pipeline control line with ir in the msb
    typedef struct packed {
        logic ir; // read the input port
        logic iw; // write the output port
        logic mr; // data memory read
        logic mw; // data memory write
        logic mtr; // write back takes the memory data instead of the ALU result
        logic rw; // register file write
        logic branch; // the instruction may redirect the PC
    } ctrlWordT;

    // stack pointer action in the memory stage
    typedef enum logic [1:0] {
        STACK_NONE = 2'b00,
        STACK_PUSH = 2'b01,
        STACK_POP  = 2'b11
    } stackOpT;

    // which half of a two-cycle CALL, RET or interrupt is in flight
    typedef enum logic [1:0] {
        PHASE_NONE   = 2'b00,
        PHASE_SECOND = 2'b01, // upper half of the PC
        PHASE_FIRST  = 2'b11 // lower half of the PC
    } phaseT;

    // the decoder tells the sequencer which multi-cycle instruction has started
    typedef enum logic [1:0] {
        START_NONE = 2'b00,
        START_LDM  = 2'b01,
        START_CALL = 2'b10,
        START_RET  = 2'b11 // RET and RTI share the same sequence
    } seqStartT;

    // state of the sequencer
    typedef enum logic [2:0] {
        SEQ_IDLE  = 3'd0,
        SEQ_LDM2  = 3'd1, // immediate word of LDM is in decode
        SEQ_CALL2 = 3'd2,
        SEQ_RET2  = 3'd3,
        SEQ_INT1  = 3'd4, // interrupt entry deferred behind LDM
        SEQ_INT2  = 3'd5
    } seqStateT;

endpackage

/* hw/controlUnit_defines.svh */
`ifndef CONTROL_UNIT_DEFINES_SVH
`define CONTROL_UNIT_DEFINES_SVH

// field widths of the control unit
`define OPCODE_W 5 // opcode field of the 16-bit instruction
`define ALUOP_W 5 // ALU operation select
`define FLUSH_CNT_W 2 // width of the flush counter in the sequencer

// zeroed cycles that follow the second cycle of RET or RTI
`define FLUSH_AFTER_RET 2

// opcodes where any code above OP_CLRC decodes as a NOP
`define OP_NOP 5'd0
`define OP_NOT 5'd1
`define OP_INC 5'd2
`define OP_DEC 5'd3
`define OP_MOV 5'd4
`define OP_ADD 5'd5
`define OP_SUB 5'd6
`define OP_AND 5'd7
`define OP_OR 5'd8
`define OP_SHL 5'd9
`define OP_SHR 5'd10
`define OP_PUSH 5'd11
`define OP_POP 5'd12
`define OP_LDM 5'd13 // two cycles with the immediate in the next slot
`define OP_LDD 5'd14
`define OP_STD 5'd15
`define OP_JZ 5'd16
`define OP_JN 5'd17
`define OP_JC 5'd18
`define OP_JMP 5'd19
`define OP_CALL 5'd20 // two cycles that push the return PC in two halves
`define OP_RET 5'd21 // two cycles plus the flush
`define OP_RTI 5'd22 // like RET but the ALU restores the frozen flags
`define OP_OUT 5'd23
`define OP_IN 5'd24
`define OP_SETC 5'd25
`define OP_CLRC 5'd26

// ALU operation codes
`define ALU_NOP 5'd0
`define ALU_NOT 5'd1
`define ALU_INC 5'd2
`define ALU_DEC 5'd3
`define ALU_MOV 5'd4
`define ALU_ADD 5'd5
`define ALU_SUB 5'd6
`define ALU_AND 5'd7
`define ALU_OR 5'd8
`define ALU_SHL 5'd9
`define ALU_SHR 5'd10
`define ALU_LDD 5'd11 // effective address for a load
`define ALU_STD 5'd12 // passes Rdst through to the memory stage
`define ALU_JZ 5'd13
`define ALU_JN 5'd14
`define ALU_JC 5'd15
`define ALU_JMP 5'd16
`define ALU_RTI 5'd17
`define ALU_SETC 5'd18
`define ALU_CLRC 5'd19

`endif

/* hw/instrSequencer.sv */
`include "controlUnit_defines.svh"

module instrSequencer import controlUnitPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic                bubble, // decode slot holds a stall
    input  logic                interrupt, // one cycle pulse
    input  ctrlWordT            decCtrl,
    input  logic [`ALUOP_W-1:0] decAluOp,
    input  logic                decShift,
    input  stackOpT             decStackOp,
    input  logic                decIsPush,
    input  logic                decIsIn,
    input  phaseT               decCallPhase,
    input  phaseT               decRetPhase,
    input  seqStartT            seqStart,
    output ctrlWordT            ctrl,
    output logic [`ALUOP_W-1:0] aluOp,
    output logic                shift,
    output stackOpT             stackOp,
    output logic                isPush,
    output logic                isIn,
    output phaseT               callPhase,
    output phaseT               retPhase,
    output phaseT               intPhase
);

    seqStateT                 seqState;
    seqStateT                 nextState;
    logic [`FLUSH_CNT_W-1:0]  flushCnt; // zeroed slots still owed after a RET
    logic [`FLUSH_CNT_W-1:0]  nextFlush;

    // output selection and next state follow one priority chain
    always_comb begin
        ctrl      = '0; // most branches only raise a few lines
        aluOp     = `ALU_NOP;
        shift     = 1'b0;
        stackOp   = STACK_NONE;
        isPush    = 1'b0;
        isIn      = 1'b0;
        callPhase = PHASE_NONE;
        retPhase  = PHASE_NONE;
        intPhase  = PHASE_NONE;
        nextState = seqState;
        nextFlush = flushCnt;

        if (seqState == SEQ_INT2) begin
            // upper PC half of the interrupt return address
            ctrl.mw   = 1'b1;
            stackOp   = STACK_PUSH;
            intPhase  = PHASE_SECOND;
            nextState = SEQ_IDLE;
        end else if (seqState == SEQ_INT1) begin
            // the interrupt that waited behind LDM starts now
            ctrl.mw   = 1'b1;
            stackOp   = STACK_PUSH;
            intPhase  = PHASE_FIRST;
            nextState = SEQ_INT2;
        end else if (interrupt && seqState == SEQ_LDM2) begin
            // LDM must finish its write first so entry slips by one cycle
            ctrl.rw   = 1'b1;
            aluOp     = `ALU_MOV;
            nextState = SEQ_INT1;
        end else if (interrupt) begin
            ctrl.mw   = 1'b1; // lower PC half is pushed as it is
            stackOp   = STACK_PUSH;
            intPhase  = PHASE_FIRST;
            nextState = SEQ_INT2; // a pending CALL2 or RET2 is abandoned
        end else if (flushCnt != '0) begin
            // wrong-path slots fetched before the new PC was known
            nextFlush = flushCnt - 1'b1;
        end else if (bubble) begin
            // a stall slot keeps the state
            nextState = seqState;
        end else if (seqState == SEQ_LDM2) begin
            ctrl.rw   = 1'b1; // immediate word is written to Rdst
            aluOp     = `ALU_MOV;
            nextState = SEQ_IDLE;
        end else if (seqState == SEQ_CALL2) begin
            ctrl.mw   = 1'b1;
            stackOp   = STACK_PUSH;
            callPhase = PHASE_SECOND; // upper PC half is pushed
            nextState = SEQ_IDLE;
        end else if (seqState == SEQ_RET2) begin
            ctrl.mr   = 1'b1;
            aluOp     = `ALU_MOV;
            stackOp   = STACK_POP;
            retPhase  = PHASE_SECOND; // popped word fills the lower PC half
            nextFlush = `FLUSH_CNT_W'(`FLUSH_AFTER_RET);
            nextState = SEQ_IDLE;
        end else begin
            // plain decode of the current opcode
            ctrl      = decCtrl;
            aluOp     = decAluOp;
            shift     = decShift;
            stackOp   = decStackOp;
            isPush    = decIsPush;
            isIn      = decIsIn;
            callPhase = decCallPhase;
            retPhase  = decRetPhase;
            case (seqStart)
                START_LDM:  nextState = SEQ_LDM2;
                START_CALL: nextState = SEQ_CALL2;
                START_RET:  nextState = SEQ_RET2;
                default:    nextState = SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            seqState <= SEQ_IDLE;
            flushCnt <= '0;
        end else begin
            seqState <= nextState;
            flushCnt <= nextFlush;
        end
    end

    // the flush is only ever loaded with the RET length and counts down from there
    flushBounded: assert property (
        @(posedge clk) disable iff (!arstN)
        flushCnt <= `FLUSH_CNT_W'(`FLUSH_AFTER_RET)
    );

    // a memory write and a pop in the same slot would corrupt the stack
    noPopOnWrite: assert property (
        @(posedge clk) disable iff (!arstN)
        !(ctrl.mw && stackOp == STACK_POP)
    );

    // the second interrupt cycle follows either the first one or an accepted interrupt
    int2Entry: assert property (
        @(posedge clk) disable iff (!arstN)
        seqState == SEQ_INT2 |->
            $past(seqState == SEQ_INT1 ||
                  (interrupt && seqState inside {SEQ_IDLE, SEQ_CALL2, SEQ_RET2}))
    );

endmodule

/* hw/opcodeDecoder.sv */
`include "controlUnit_defines.svh"

module opcodeDecoder import controlUnitPkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    output ctrlWordT             ctrl,
    output logic [`ALUOP_W-1:0]  aluOp,
    output logic                 shift,
    output stackOpT              stackOp,
    output logic                 isPush,
    output logic                 isIn,
    output phaseT                callPhase,
    output phaseT                retPhase,
    output seqStartT             seqStart
);

    // decodes the first cycle of every instruction while the sequencer supplies the later ones
    always_comb begin
        // everything inactive unless the opcode says otherwise
        ctrl      = '0;
        aluOp     = `ALU_NOP;
        shift     = 1'b0;
        stackOp   = STACK_NONE;
        isPush    = 1'b0;
        isIn      = 1'b0;
        callPhase = PHASE_NONE;
        retPhase  = PHASE_NONE;
        seqStart  = START_NONE;

        case (opcode)
            // register to register ALU work only writes back the result
            `OP_NOT: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_NOT;
            end
            `OP_INC: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_INC;
            end
            `OP_DEC: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_DEC;
            end
            `OP_MOV: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_MOV;
            end
            `OP_ADD: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_ADD;
            end
            `OP_SUB: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_SUB;
            end
            `OP_AND: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_AND;
            end
            `OP_OR: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_OR;
            end
            `OP_SHL: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_SHL;
                shift   = 1'b1; // shift amount comes from the immediate field
            end
            `OP_SHR: begin
                ctrl.rw = 1'b1;
                aluOp   = `ALU_SHR;
                shift   = 1'b1;
            end
            `OP_PUSH: begin
                ctrl.mw = 1'b1;
                aluOp   = `ALU_MOV; // Rdst goes through the ALU to the memory data
                stackOp = STACK_PUSH;
                isPush  = 1'b1; // memory stage picks the ALU result as write data
            end
            `OP_POP: begin
                ctrl.mr  = 1'b1;
                ctrl.mtr = 1'b1;
                ctrl.rw  = 1'b1;
                aluOp    = `ALU_MOV;
                stackOp  = STACK_POP;
            end
            `OP_LDM: begin
                seqStart = START_LDM; // this slot is a bubble and the write happens next cycle
            end
            `OP_LDD: begin
                ctrl.mr  = 1'b1;
                ctrl.mtr = 1'b1;
                ctrl.rw  = 1'b1;
                aluOp    = `ALU_LDD;
            end
            `OP_STD: begin
                ctrl.mw = 1'b1;
                aluOp   = `ALU_STD;
            end
            // jumps only need the ALU to evaluate the condition
            `OP_JZ:  aluOp = `ALU_JZ;
            `OP_JN:  aluOp = `ALU_JN;
            `OP_JC:  aluOp = `ALU_JC;
            `OP_JMP: aluOp = `ALU_JMP;
            `OP_CALL: begin
                ctrl.mw   = 1'b1;
                aluOp     = `ALU_STD; // target address is Rdst
                stackOp   = STACK_PUSH;
                callPhase = PHASE_FIRST; // lower half of PC + 1 is pushed now
                seqStart  = START_CALL;
            end
            `OP_RET: begin
                ctrl.mr  = 1'b1;
                aluOp    = `ALU_MOV;
                stackOp  = STACK_POP;
                retPhase = PHASE_FIRST; // popped word goes to the upper PC half
                seqStart = START_RET;
            end
            `OP_RTI: begin
                ctrl.mr  = 1'b1;
                aluOp    = `ALU_RTI; // flags are restored from the frozen copy
                stackOp  = STACK_POP;
                retPhase = PHASE_FIRST;
                seqStart = START_RET;
            end
            `OP_OUT: begin
                ctrl.iw = 1'b1;
                aluOp   = `ALU_MOV; // Rdst is moved to the output port
            end
            `OP_IN: begin
                ctrl.ir = 1'b1;
                ctrl.rw = 1'b1;
                aluOp   = `ALU_MOV;
                isIn    = 1'b1; // write back takes the port value
            end
            `OP_SETC: aluOp = `ALU_SETC;
            `OP_CLRC: aluOp = `ALU_CLRC;
            default: begin
                // OP_NOP and every unused code keep the inactive word
                aluOp = `ALU_NOP;
            end
        endcase
    end

endmodule
